// ==== logic/core_types_pkg.sv ====
package core_types_pkg;

  // machine word and result tags shared by the whole core
  localparam int WORD_W = 32;
  localparam int ROB_RID_W = 5;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ROB_RID_W-1:0] rob_rid_t; // rob slot that produces a result

  // one common data bus beat
  typedef struct packed {
    logic     valid; // beat carries a result
    rob_rid_t rid;   // producer tag
    word_t    data;  // result value
  } cdb_t;

endpackage

// ==== logic/iq_pkg.sv ====
package iq_pkg;

  // dispatch format is fixed at two source operands
  localparam int RREG_CNT = 2;

  // opcode field fills the rest of the 24-bit micro-op
  localparam int OPCODE_W = 18;

  typedef logic [OPCODE_W-1:0] opcode_t;

  // decoded control bits that ride along with the instruction
  typedef struct packed {
    opcode_t                  opcode;
    core_types_pkg::rob_rid_t dst_rid;  // result tag for this op
    logic                     imm_flag; // second operand is an immediate
  } uop_payload_t;

endpackage

// ==== logic/iq_dispatch_if.sv ====
`timescale 1ns/1ps

// one dispatched instruction, seen by every entry of the queue
interface iq_dispatch_if #(
  parameter type payload_t = logic,
  parameter int  IQ_DEPTH  = 4
);
  import core_types_pkg::*;
  import iq_pkg::*;

  logic                    valid;      // single cycle strobe
  logic [IQ_DEPTH-1:0]     slot_sel;   // one-hot target entry
  logic [RREG_CNT-1:0]     src_valid;  // operand already available
  rob_rid_t [RREG_CNT-1:0] src_rid;    // producer tag when waiting
  word_t [RREG_CNT-1:0]    src_data;
  logic [RREG_CNT-1:0]     ready_mask; // set bits do not block issue
  payload_t                payload;

  modport src (
    output valid, slot_sel, src_valid, src_rid, src_data, ready_mask, payload
  );

  modport dst (
    input valid, slot_sel, src_valid, src_rid, src_data, ready_mask, payload
  );

endinterface

// ==== logic/iq_entry_ctrl.sv ====
`timescale 1ns/1ps

module iq_entry_ctrl #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n_i,
  input  logic     write_i,   // new instruction lands here
  input  logic     pick_i,    // entry chosen for issue
  input  payload_t payload_i,
  output payload_t payload_o,
  output logic     valid_o
);

  logic     valid_q;
  payload_t payload_q;

  // occupancy flag
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (write_i) begin
      valid_q <= 1'b1;
    end else if (pick_i) begin
      valid_q <= 1'b0; // leaves the queue once picked
    end
  end

  always_ff @(posedge clk) begin
    if (write_i) begin
      payload_q <= payload_i;
    end
  end

  assign valid_o   = valid_q;
  assign payload_o = payload_q;

  // picker only selects entries whose registered ready was set while occupied
  a_pick_hits_valid: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    pick_i |-> valid_q
  ) else $error("pick on an empty issue queue entry");

  // the slot allocator never targets an occupied entry
  a_write_hits_empty: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    write_i |-> !valid_q
  ) else $error("dispatch into an occupied issue queue entry");

endmodule

// ==== logic/iq_entry_operand.sv ====
`timescale 1ns/1ps

module iq_entry_operand #(
  parameter int CDB_COUNT      = 2,
  parameter int WAKEUP_SRC_CNT = 2
) (
  input  logic                                          clk,
  input  logic                                          arst_n_i,
  input  logic                                          write_i,
  input  logic                                          src_valid_i,
  input  core_types_pkg::rob_rid_t                      src_rid_i,
  input  core_types_pkg::word_t                         src_data_i,
  input  logic [WAKEUP_SRC_CNT-1:0]                     wkup_valid_i,
  input  core_types_pkg::rob_rid_t [WAKEUP_SRC_CNT-1:0] wkup_rid_i,
  input  core_types_pkg::cdb_t [CDB_COUNT-1:0]          cdb_i,
  output logic                                          ready_o,
  output logic [WAKEUP_SRC_CNT-1:0]                     wkup_sel_o, // one-hot bypass source
  output core_types_pkg::word_t                         data_o
);
  import core_types_pkg::*;

  logic                      ready_q;
  rob_rid_t                  rid_q;
  word_t                     data_q;
  logic [WAKEUP_SRC_CNT-1:0] sel_q;

  logic [WAKEUP_SRC_CNT-1:0] wkup_hit;
  logic [WAKEUP_SRC_CNT-1:0] wkup_first;
  logic                      cdb_hit;
  word_t                     cdb_data;

  // early wakeup tag compare
  always_comb begin
    for (int k = 0; k < WAKEUP_SRC_CNT; k++) begin
      wkup_hit[k] = wkup_valid_i[k] && (wkup_rid_i[k] == rid_q);
    end
  end

  // keep the select one-hot even if two sources claim the tag
  assign wkup_first = wkup_hit & (~wkup_hit + 1'b1);

  // result capture from the cdb ports
  always_comb begin
    cdb_hit  = 1'b0;
    cdb_data = '0;
    for (int c = 0; c < CDB_COUNT; c++) begin
      if (cdb_i[c].valid && (cdb_i[c].rid == rid_q)) begin
        cdb_hit  = 1'b1;
        cdb_data = cdb_i[c].data;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ready_q <= 1'b0;
    end else if (write_i) begin
      ready_q <= src_valid_i;
    end else if (!ready_q && (cdb_hit || (|wkup_hit))) begin
      ready_q <= 1'b1;
    end
  end

  // operand value, tag and bypass select
  always_ff @(posedge clk) begin
    if (write_i) begin
      rid_q  <= src_rid_i;
      data_q <= src_data_i;
      sel_q  <= '0;
    end else if (!ready_q) begin
      if (cdb_hit) begin
        data_q <= cdb_data; // value captured, no bypass needed
        sel_q  <= '0;
      end else if (|wkup_hit) begin
        sel_q <= wkup_first;
      end
    end
  end

  assign ready_o    = ready_q;
  assign wkup_sel_o = sel_q;
  assign data_o     = data_q;

endmodule

// ==== logic/iq_entry.sv ====
`timescale 1ns/1ps

module iq_entry #(
  parameter type payload_t      = logic,
  parameter int  CDB_COUNT      = 2,
  parameter int  WAKEUP_SRC_CNT = 2
) (
  input  logic                                                               clk,
  input  logic                                                               arst_n_i,
  iq_dispatch_if.dst                                                         dispatch,
  input  logic                                                               slot_sel_i,
  input  logic                                                               pick_i,
  input  logic [iq_pkg::RREG_CNT-1:0][WAKEUP_SRC_CNT-1:0]                    wkup_valid_i,
  input  core_types_pkg::rob_rid_t [iq_pkg::RREG_CNT-1:0][WAKEUP_SRC_CNT-1:0] wkup_rid_i,
  input  core_types_pkg::cdb_t [CDB_COUNT-1:0]                               cdb_i,
  output logic                                                               valid_o,
  output logic                                                               ready_o,
  output core_types_pkg::word_t [iq_pkg::RREG_CNT-1:0]                       data_o,
  output logic [iq_pkg::RREG_CNT-1:0][WAKEUP_SRC_CNT-1:0]                    wkup_sel_o,
  output payload_t                                                           payload_o
);
  import iq_pkg::*;

  logic                write;
  logic                valid;
  logic [RREG_CNT-1:0] mask_q;   // operands that never block issue
  logic [RREG_CNT-1:0] op_ready;
  logic                ready_q;

  assign write = dispatch.valid && slot_sel_i;

  iq_entry_ctrl #(
    .payload_t(payload_t)
  ) ctrl_i (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .write_i  (write),
    .pick_i   (pick_i),
    .payload_i(dispatch.payload),
    .payload_o(payload_o),
    .valid_o  (valid)
  );

  for (genvar i = 0; i < RREG_CNT; i++) begin : g_operand
    iq_entry_operand #(
      .CDB_COUNT     (CDB_COUNT),
      .WAKEUP_SRC_CNT(WAKEUP_SRC_CNT)
    ) operand_i (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .write_i     (write),
      .src_valid_i (dispatch.src_valid[i]),
      .src_rid_i   (dispatch.src_rid[i]),
      .src_data_i  (dispatch.src_data[i]),
      .wkup_valid_i(wkup_valid_i[i]),
      .wkup_rid_i  (wkup_rid_i[i]),
      .cdb_i       (cdb_i),
      .ready_o     (op_ready[i]),
      .wkup_sel_o  (wkup_sel_o[i]),
      .data_o      (data_o[i])
    );
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mask_q <= dispatch.ready_mask;
    end
  end

  // registered ready, dropped on the pick cycle so an entry issues once
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= valid && !pick_i && (&(op_ready | mask_q));
    end
  end

  assign valid_o = valid;
  assign ready_o = ready_q;

endmodule

// ==== logic/iq_slot_picker.sv ====
`timescale 1ns/1ps

module iq_slot_picker #(
  parameter int IQ_DEPTH = 4
) (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic [IQ_DEPTH-1:0] entry_valid_i,
  input  logic [IQ_DEPTH-1:0] entry_ready_i,
  output logic [IQ_DEPTH-1:0] free_slot_o,  // one-hot lowest empty entry
  output logic                full_o,
  output logic [IQ_DEPTH-1:0] pick_o,       // one-hot lowest ready entry
  output logic                pick_valid_o
);

  logic [IQ_DEPTH-1:0] empty;

  assign empty = ~entry_valid_i;

  // isolate lowest set bit
  assign free_slot_o = empty & (~empty + 1'b1);
  assign full_o      = &entry_valid_i;

  assign pick_o       = entry_ready_i & (~entry_ready_i + 1'b1);
  assign pick_valid_o = |entry_ready_i;

  a_free_onehot: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    $onehot0(free_slot_o)
  ) else $error("free slot select is not one-hot");

  a_pick_onehot: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    $onehot0(pick_o)
  ) else $error("pick select is not one-hot");

endmodule

// ==== logic/issue_queue.sv ====
`timescale 1ns/1ps

module issue_queue #(
  parameter int IQ_DEPTH       = 4,
  parameter int CDB_COUNT      = 2,
  parameter int WAKEUP_SRC_CNT = 2
) (
  input  logic                                                               clk,
  input  logic                                                               arst_n_i,
  input  logic                                                               dispatch_valid_i,
  input  logic [iq_pkg::RREG_CNT-1:0]                                        dispatch_src_valid_i,
  input  core_types_pkg::rob_rid_t [iq_pkg::RREG_CNT-1:0]                    dispatch_src_rid_i,
  input  core_types_pkg::word_t [iq_pkg::RREG_CNT-1:0]                       dispatch_src_data_i,
  input  logic [iq_pkg::RREG_CNT-1:0]                                        dispatch_ready_mask_i,
  input  iq_pkg::uop_payload_t                                               dispatch_payload_i,
  input  logic [iq_pkg::RREG_CNT-1:0][WAKEUP_SRC_CNT-1:0]                    wkup_valid_i,
  input  core_types_pkg::rob_rid_t [iq_pkg::RREG_CNT-1:0][WAKEUP_SRC_CNT-1:0] wkup_rid_i,
  input  core_types_pkg::cdb_t [CDB_COUNT-1:0]                               cdb_i,
  output logic                                                               full_o,
  output logic                                                               issue_valid_o,
  output iq_pkg::uop_payload_t                                               issue_payload_o,
  output core_types_pkg::word_t [iq_pkg::RREG_CNT-1:0]                       issue_data_o,
  output logic [iq_pkg::RREG_CNT-1:0][WAKEUP_SRC_CNT-1:0]                    issue_wkup_sel_o
);
  import core_types_pkg::*;
  import iq_pkg::*;

  logic [IQ_DEPTH-1:0] entry_valid;
  logic [IQ_DEPTH-1:0] entry_ready;
  logic [IQ_DEPTH-1:0] free_slot;
  logic [IQ_DEPTH-1:0] pick;
  logic                pick_valid;

  word_t [IQ_DEPTH-1:0][RREG_CNT-1:0]                    entry_data;
  logic [IQ_DEPTH-1:0][RREG_CNT-1:0][WAKEUP_SRC_CNT-1:0] entry_sel;
  uop_payload_t [IQ_DEPTH-1:0]                           entry_payload;

  word_t [RREG_CNT-1:0]                    pick_data;
  logic [RREG_CNT-1:0][WAKEUP_SRC_CNT-1:0] pick_sel;
  uop_payload_t                            pick_payload;

  iq_dispatch_if #(.payload_t(uop_payload_t), .IQ_DEPTH(IQ_DEPTH)) disp_bus ();

  assign disp_bus.valid      = dispatch_valid_i;
  assign disp_bus.slot_sel   = free_slot; // lowest empty entry takes it
  assign disp_bus.src_valid  = dispatch_src_valid_i;
  assign disp_bus.src_rid    = dispatch_src_rid_i;
  assign disp_bus.src_data   = dispatch_src_data_i;
  assign disp_bus.ready_mask = dispatch_ready_mask_i;
  assign disp_bus.payload    = dispatch_payload_i;

  for (genvar i = 0; i < IQ_DEPTH; i++) begin : g_entry
    iq_entry #(
      .payload_t     (uop_payload_t),
      .CDB_COUNT     (CDB_COUNT),
      .WAKEUP_SRC_CNT(WAKEUP_SRC_CNT)
    ) entry_i (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .dispatch    (disp_bus.dst),
      .slot_sel_i  (disp_bus.slot_sel[i]),
      .pick_i      (pick[i]),
      .wkup_valid_i(wkup_valid_i),
      .wkup_rid_i  (wkup_rid_i),
      .cdb_i       (cdb_i),
      .valid_o     (entry_valid[i]),
      .ready_o     (entry_ready[i]),
      .data_o      (entry_data[i]),
      .wkup_sel_o  (entry_sel[i]),
      .payload_o   (entry_payload[i])
    );
  end

  iq_slot_picker #(
    .IQ_DEPTH(IQ_DEPTH)
  ) picker_i (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .entry_valid_i(entry_valid),
    .entry_ready_i(entry_ready),
    .free_slot_o  (free_slot),
    .full_o       (full_o),
    .pick_o       (pick),
    .pick_valid_o (pick_valid)
  );

  // one-hot mux of the picked entry
  always_comb begin
    pick_data    = '0;
    pick_sel     = '0;
    pick_payload = '0;
    for (int i = 0; i < IQ_DEPTH; i++) begin
      if (pick[i]) begin
        pick_data    = entry_data[i];
        pick_sel     = entry_sel[i];
        pick_payload = entry_payload[i];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      issue_valid_o <= 1'b0;
    end else begin
      issue_valid_o <= pick_valid; // execute always accepts
    end
  end

  always_ff @(posedge clk) begin
    if (pick_valid) begin
      issue_payload_o  <= pick_payload;
      issue_data_o     <= pick_data;
      issue_wkup_sel_o <= pick_sel;
    end
  end

  a_no_dispatch_when_full: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    dispatch_valid_i |-> !full_o
  ) else $error("dispatch while issue queue is full");

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic arst_n_o
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 arst_n_o = 1'b1; // release away from the edge
  end

endmodule

// ==== test/tb_issue_queue.sv ====
`timescale 1ns/1ps

module tb_issue_queue;
  import core_types_pkg::*;
  import iq_pkg::*;

  localparam int IQ_DEPTH       = 4;
  localparam int CDB_COUNT      = 2;
  localparam int WAKEUP_SRC_CNT = 2;
  localparam int RESET_CYCLES   = 16;
  localparam int TEST_CNT       = 6;
  localparam int DRAIN_CYCLES   = 30;

  // what the issue ports should show for one instruction
  typedef struct packed {
    uop_payload_t                            payload;
    word_t [RREG_CNT-1:0]                    data;
    logic [RREG_CNT-1:0][WAKEUP_SRC_CNT-1:0] sel;
  } issue_t;

  logic clk;
  logic arst_n;

  logic                                                dispatch_valid_i;
  logic [RREG_CNT-1:0]                                 dispatch_src_valid_i;
  rob_rid_t [RREG_CNT-1:0]                             dispatch_src_rid_i;
  word_t [RREG_CNT-1:0]                                dispatch_src_data_i;
  logic [RREG_CNT-1:0]                                 dispatch_ready_mask_i;
  uop_payload_t                                        dispatch_payload_i;
  logic [RREG_CNT-1:0][WAKEUP_SRC_CNT-1:0]             wkup_valid_i;
  rob_rid_t [RREG_CNT-1:0][WAKEUP_SRC_CNT-1:0]         wkup_rid_i;
  cdb_t [CDB_COUNT-1:0]                                cdb_i;
  logic                                                full_o;
  logic                                                issue_valid_o;
  uop_payload_t                                        issue_payload_o;
  word_t [RREG_CNT-1:0]                                issue_data_o;
  logic [RREG_CNT-1:0][WAKEUP_SRC_CNT-1:0]             issue_wkup_sel_o;

  issue_t      exp_q [int];     // scoreboard keyed by dst tag
  int          disp_cyc [int];
  int          order_q [$];     // expected issue order when it matters
  logic [31:0] lfsr_q = 32'h6c32f56a;
  rob_rid_t    next_dst = '0;
  int          cyc = 0;
  int          errors = 0;
  int          issued = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  bit          quiet = 1'b0;

  tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(RESET_CYCLES)) clk_gen_i (
    .clk     (clk),
    .arst_n_o(arst_n)
  );

  issue_queue #(
    .IQ_DEPTH      (IQ_DEPTH),
    .CDB_COUNT     (CDB_COUNT),
    .WAKEUP_SRC_CNT(WAKEUP_SRC_CNT)
  ) dut_i (
    .clk                  (clk),
    .arst_n_i             (arst_n),
    .dispatch_valid_i     (dispatch_valid_i),
    .dispatch_src_valid_i (dispatch_src_valid_i),
    .dispatch_src_rid_i   (dispatch_src_rid_i),
    .dispatch_src_data_i  (dispatch_src_data_i),
    .dispatch_ready_mask_i(dispatch_ready_mask_i),
    .dispatch_payload_i   (dispatch_payload_i),
    .wkup_valid_i         (wkup_valid_i),
    .wkup_rid_i           (wkup_rid_i),
    .cdb_i                (cdb_i),
    .full_o               (full_o),
    .issue_valid_o        (issue_valid_o),
    .issue_payload_o      (issue_payload_o),
    .issue_data_o         (issue_data_o),
    .issue_wkup_sel_o     (issue_wkup_sel_o)
  );

  always @(posedge clk) cyc <= cyc + 1;

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // strobes last exactly one cycle
  task automatic next_cycle();
    @(posedge clk);
    #1;
    dispatch_valid_i = 1'b0;
    wkup_valid_i     = '0;
    cdb_i            = '0;
  endtask

  task automatic send_dispatch(
    input logic [RREG_CNT-1:0]     vld,
    input rob_rid_t [RREG_CNT-1:0] rid,
    input word_t [RREG_CNT-1:0]    data,
    input logic [RREG_CNT-1:0]     mask,
    input issue_t                  exp,
    input bit                      track
  );
    uop_payload_t pl;
    issue_t       rec;
    pl.opcode   = rand_bits(OPCODE_W);
    pl.dst_rid  = next_dst;
    pl.imm_flag = rand_bits(1);
    next_dst++;
    next_cycle();
    dispatch_valid_i      = 1'b1;
    dispatch_src_valid_i  = vld;
    dispatch_src_rid_i    = rid;
    dispatch_src_data_i   = data;
    dispatch_ready_mask_i = mask;
    dispatch_payload_i    = pl;
    if (track) begin
      rec         = exp;
      rec.payload = pl;
      exp_q[int'(pl.dst_rid)]    = rec;
      disp_cyc[int'(pl.dst_rid)] = cyc;
    end
  endtask

  task automatic send_cdb(input int port, input rob_rid_t rid, input word_t data);
    cdb_i[port] = '{valid: 1'b1, rid: rid, data: data};
  endtask

  task automatic send_wkup(input int op, input int src, input rob_rid_t rid);
    wkup_valid_i[op][src] = 1'b1;
    wkup_rid_i[op][src]   = rid;
  endtask

  task automatic wait_drain();
    int guard;
    guard = 0;
    while (exp_q.size() != 0 && guard < DRAIN_CYCLES) begin
      next_cycle();
      guard++;
    end
    a_drained: assert (exp_q.size() == 0) else begin
      $display("%0t: %0d instructions were never issued", $time, exp_q.size());
      errors++;
    end
    repeat (2) next_cycle();
  endtask

  task automatic end_test(input string name, input int err_mark);
    tests_run++;
    if (errors == err_mark) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - err_mark);
    end
  endtask

  a_quiet: assert property (@(posedge clk) quiet |-> (!issue_valid_o && !full_o))
    else begin
      $display("Mismatch at %0t: issue_valid_o or full_o high in an idle queue", $time);
      errors++;
    end

  a_known: assert property (
    @(posedge clk) disable iff (!arst_n) !$isunknown({issue_valid_o, full_o})
  ) else begin
    $display("issue_valid_o or full_o is unknown at %0t", $time);
    errors++;
  end

  // compare every issue with the scoreboard at the falling edge
  always @(negedge clk) begin : issue_check
    int     tag;
    issue_t got;
    if (arst_n && issue_valid_o) begin
      tag         = int'(issue_payload_o.dst_rid);
      got.payload = issue_payload_o;
      got.data    = issue_data_o;
      got.sel     = issue_wkup_sel_o;
      a_issue_expected: assert (exp_q.exists(tag)) else begin
        $display("%0t: tag %0d issued without a pending dispatch", $time, tag);
        errors++;
      end
      if (exp_q.exists(tag)) begin
        a_issue_value: assert (got == exp_q[tag]) else begin
          $display("Mismatch at %0t: tag %0d got %h expected %h", $time, tag, got, exp_q[tag]);
          errors++;
        end
        a_issue_latency: assert (cyc - disp_cyc[tag] >= 3) else begin
          $display("Mismatch at %0t: tag %0d issued %0d cycles after dispatch", $time, tag,
                   cyc - disp_cyc[tag]);
          errors++;
        end
        exp_q.delete(tag);
        issued++;
      end
      if (order_q.size() != 0) begin
        a_issue_order: assert (tag == order_q[0]) else begin
          $display("Mismatch at %0t: issued tag %0d, expected tag %0d", $time, tag, order_q[0]);
          errors++;
        end
        void'(order_q.pop_front());
      end
    end
  end

  initial begin : stimulus
    logic [RREG_CNT-1:0]     vld;
    logic [RREG_CNT-1:0]     mask;
    logic [RREG_CNT-1:0]     wait_mask;
    rob_rid_t [RREG_CNT-1:0] rid;
    word_t [RREG_CNT-1:0]    data;
    word_t [RREG_CNT-1:0]    ans;
    word_t                   ent_ans [IQ_DEPTH];
    int                      ent_tag [IQ_DEPTH];
    issue_t                  exp;
    rob_rid_t                base;
    int                      w;
    int                      k;
    int                      r;
    int                      err_mark;

    dispatch_valid_i      = 1'b0;
    dispatch_src_valid_i  = '0;
    dispatch_src_rid_i    = '0;
    dispatch_src_data_i   = '0;
    dispatch_ready_mask_i = '0;
    dispatch_payload_i    = '0;
    wkup_valid_i          = '0;
    wkup_rid_i            = '0;
    cdb_i                 = '0;
    exp                   = '0;
    wait (arst_n == 1'b1);

    err_mark = errors;
    quiet = 1'b1;
    repeat (20) next_cycle();
    quiet = 1'b0;
    end_test("idle after reset", err_mark);

    err_mark = errors;
    for (int n = 0; n < 3; n++) begin
      for (int i = 0; i < RREG_CNT; i++) begin
        rid[i]  = rand_bits(5);
        data[i] = rand_bits(32);
      end
      exp.data = data; // nothing to capture so values pass through
      exp.sel  = '0;
      send_dispatch(2'b11, rid, data, 2'b00, exp, 1'b1);
    end
    wait_drain();
    end_test("operands ready at dispatch", err_mark);

    err_mark = errors;
    for (int n = 0; n < 3; n++) begin
      wait_mask = rand_bits(2);
      if (wait_mask == '0) wait_mask = 2'b01;
      base = rand_bits(5);
      r    = rand_bits(1);
      for (int i = 0; i < RREG_CNT; i++) begin
        rid[i]      = base ^ rob_rid_t'(i);
        data[i]     = rand_bits(32);
        ans[i]      = rand_bits(32);
        exp.data[i] = wait_mask[i] ? ans[i] : data[i];
      end
      exp.sel = '0;
      send_dispatch(~wait_mask, rid, data, 2'b00, exp, 1'b1);
      repeat (1 + rand_bits(2)) next_cycle();
      for (int i = 0; i < RREG_CNT; i++) begin
        if (wait_mask[i]) send_cdb(i ^ r, rid[i], ans[i]); // distinct ports
      end
    end
    wait_drain();
    end_test("cdb capture", err_mark);

    err_mark = errors;
    for (int n = 0; n < 3; n++) begin
      w    = rand_bits(1);
      k    = rand_bits(1);
      base = rand_bits(5);
      rid[w]     = base;
      rid[1 - w] = base ^ 5'h10; // never broadcast
      data[0]    = rand_bits(32);
      data[1]    = rand_bits(32);
      mask       = '0;
      mask[1 - w] = (n == 0) ? 1'b1 : rand_bits(1); // first op always masked
      vld        = '0;
      vld[1 - w] = !mask[1 - w];
      exp.data   = data;
      exp.sel    = '0;
      exp.sel[w] = WAKEUP_SRC_CNT'(1) << k;
      send_dispatch(vld, rid, data, mask, exp, 1'b1);
      repeat (1 + rand_bits(2)) next_cycle();
      send_wkup(w, k, rid[w]);
    end
    wait_drain();
    end_test("early wakeup and ready mask", err_mark);

    err_mark = errors;
    for (int e = 0; e < IQ_DEPTH; e++) begin
      rid        = '0;
      rid[0]     = rob_rid_t'(8 + e);
      data[0]    = rand_bits(32);
      data[1]    = rand_bits(32);
      ent_ans[e] = rand_bits(32);
      ent_tag[e] = int'(next_dst);
      exp.data   = data;
      exp.sel    = '0;
      if (e >= 2) exp.data[0] = ent_ans[e];       // answered by cdb
      else exp.sel[0] = WAKEUP_SRC_CNT'(1) << e;  // entry e woken by source e
      send_dispatch(2'b10, rid, data, 2'b00, exp, 1'b1);
    end
    next_cycle();
    @(negedge clk);
    a_full: assert (full_o) else begin
      $display("Mismatch at %0t: full_o low with every entry occupied", $time);
      errors++;
    end
    // 3 and 2 ready together and 0 and 1 arrive before 3 gets its turn
    order_q = '{ent_tag[2], ent_tag[0], ent_tag[1], ent_tag[3]};
    next_cycle();
    send_cdb(0, rob_rid_t'(11), ent_ans[3]);
    send_cdb(1, rob_rid_t'(10), ent_ans[2]);
    next_cycle();
    send_wkup(0, 1, rob_rid_t'(9));
    send_wkup(0, 0, rob_rid_t'(8));
    wait_drain();
    a_order_done: assert (order_q.size() == 0) else begin
      $display("%0t: full queue did not issue every entry", $time);
      errors++;
    end
    end_test("full queue release order", err_mark);

    err_mark = errors;
    rid    = '0;
    rid[0] = 5'h1f;
    data   = '0;
    send_dispatch(2'b10, rid, data, 2'b00, exp, 1'b0);
    for (int n = 0; n < 40; n++) begin
      next_cycle();
      send_cdb(rand_bits(1), rand_bits(4), rand_bits(32)); // tags below 16 only
      send_wkup(rand_bits(1), rand_bits(1), rand_bits(4));
    end
    repeat (4) next_cycle();
    end_test("unmatched tag never issues", err_mark);

    $display("tests %0d, failed %0d, issued %0d, errors %0d",
             tests_run, tests_failed, issued, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (RESET_CYCLES + TEST_CNT * 200) @(posedge clk);
    $display("watchdog expired, the run did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== sources.f ====
logic/core_types_pkg.sv
logic/iq_pkg.sv
logic/iq_dispatch_if.sv
logic/iq_entry_ctrl.sv
logic/iq_entry_operand.sv
logic/iq_entry.sv
logic/iq_slot_picker.sv
logic/issue_queue.sv
test/tb_clock_gen.sv
test/tb_issue_queue.sv
